// ==== mips32.f ====
source/mips32Pkg.sv
source/pipeReg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/mips32Top.sv
test/clockGen.sv
test/mips32Tb.sv

// ==== Bender.yml ====
package:
  name: mips32

sources:
  - source/mips32Pkg.sv
  - source/pipeReg.sv
  - source/fetchStage.sv
  - source/decodeStage.sv
  - source/executeStage.sv
  - source/memoryStage.sv
  - source/mips32Top.sv
  - target: test
    files:
      - test/clockGen.sv
      - test/mips32Tb.sv

// ==== test/mips32Stim.txt ====
// line 1: program word count, register write count, store count (all hex)
// then program words, register writes as (reg value), stores as (address data)
23 11 4
// 0-3: addiu $1,$0,5; addiu $2,$0,-3; addu $3,$1,$2; subu $4,$2,$1
24010005 2402FFFD 00221821 00412023
// 4-7: slt $5,$2,$1; slt $6,$1,$2; and $7,$2,$4; or $8,$1,$3
0041282A 0022302A 00443824 00234025
// 8-11: addiu $0,$1,9; addu $9,$0,$1; sw $8,16($0); lw $10,16($0)
24200009 00014821 AC080010 8C0A0010
// 12-15: addu $11,$10,$1; sw $11,20($0); lw $12,20($0); sw $12,24($0)
01415821 AC0B0014 8C0C0014 AC0C0018
// 16-19: beq $1,$9,+1; addiu $13,$0,99; addiu $13,$0,1; bne $13,$1,+1
10290001 240D0063 240D0001 15A10001
// 20-23: addiu $14,$0,77; beq $13,$1,+1; addiu $14,$0,3; bne $14,$14,+1
240E004D 11A10001 240E0003 15CE0001
// 24-27: addiu $15,$14,-1; lw $16,16($0); beq $16,$8,+2; addiu $17,$0,55
25CFFFFF 8C100010 12080002 24110037
// 28-31: addiu $17,$0,66; j 32; addiu $18,$0,11; sw $1,0($0)
24110042 08000020 2412000B AC010000
// 32-34: addiu $18,$15,100; sw $18,28($0); j 34
25F20064 AC12001C 08000022
// register writes in program order
01 00000005 02 FFFFFFFD 03 00000002 04 FFFFFFF8
05 00000001 06 00000000 07 FFFFFFF8 08 00000007
09 00000005 0A 00000007 0B 0000000C 0C 0000000C
0D 00000001 0E 00000003 0F 00000002 10 00000007
12 00000066
// stores in program order
00000010 00000007 00000014 0000000C
00000018 0000000C 0000001C 00000066

// ==== test/mips32Tb.sv ====
/*
 * Testbench for the mips32 core: loads the program from the stim file
 * while the core is in reset, then checks the register-write and store
 * strobes against the expected records from the same file.
 */
`timescale 1ns/1ps

module mips32Tb;
	import mips32Pkg::*;

	localparam int resetCycles = 16;
	localparam int drainCycles = 20;
	localparam int stimDepth = 256;
	localparam int imemWords = 64;

	logic clk;
	logic rstN;
	logic progWe;
	wordT progAddr;
	wordT progData;
	logic wbValid;
	memWbT wbRec;
	logic storeValid;
	storeT storeRec;

	wordT stim [stimDepth];
	int numProg;
	int numWb;
	int numStore;
	int wbBase;
	int storeBase;
	int wbSeen;
	int storeSeen;
	int cycles;
	int timeoutLimit;

	clockGen #(.period(20)) clkGen (.clk);

	mips32Top #(.imemWords(imemWords), .dmemWords(64)) dut0 (
		.clk, .rstN, .progWe, .progAddr, .progData,
		.wbValid, .wbRec, .storeValid, .storeRec
	);

	task automatic failRun(string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic checkWb(string testName, memWbT expected, memWbT actual);
		if (actual !== expected)
			failRun($sformatf("mismatch %s: expected reg %0d = %h, actual reg %0d = %h",
				testName, expected.destReg, expected.value, actual.destReg, actual.value));
	endtask

	task automatic checkStore(string testName, storeT expected, storeT actual);
		if (actual !== expected)
			failRun($sformatf("mismatch %s: expected [%h] = %h, actual [%h] = %h",
				testName, expected.address, expected.data, actual.address, actual.data));
	endtask

	// stim holds (reg, value) pairs after the program words
	function automatic memWbT expectedWb(int i);
		memWbT rec;
		rec.regWrite = 1'b1;
		rec.destReg = regAddrT'(stim[wbBase + 2 * i]);
		rec.value = stim[wbBase + 2 * i + 1];
		return rec;
	endfunction

	function automatic storeT expectedStore(int i);
		storeT rec;
		rec.address = stim[storeBase + 2 * i];
		rec.data = stim[storeBase + 2 * i + 1];
		return rec;
	endfunction

	// register writes sampled mid-cycle in program order
	always @(negedge clk) begin
		if (rstN && wbValid) begin
			if (wbSeen >= numWb) begin
				failRun($sformatf("unexpected register write to reg %0d after the last one",
					wbRec.destReg));
			end else begin
				wbSeen++;
				checkWb($sformatf("register write %0d", wbSeen), expectedWb(wbSeen - 1), wbRec);
			end
		end
	end

	// stores in program order
	always @(negedge clk) begin
		if (rstN && storeValid) begin
			if (storeSeen >= numStore) begin
				failRun($sformatf("unexpected store to address %h after the last one",
					storeRec.address));
			end else begin
				storeSeen++;
				checkStore($sformatf("store %0d", storeSeen), expectedStore(storeSeen - 1),
					storeRec);
			end
		end
	end

	initial begin
		rstN <= 1'b0;
		progWe <= 1'b0;
		progAddr <= '0;
		progData <= '0;
		wbSeen = 0;
		storeSeen = 0;
		cycles = 0;
		void'($urandom(32'h6ebd_63c5));

		$readmemh("test/mips32Stim.txt", stim);
		numProg = stim[0];
		numWb = stim[1];
		numStore = stim[2];
		wbBase = 3 + numProg;
		storeBase = wbBase + 2 * numWb;
		if (numProg < 1 || numProg > imemWords || storeBase + 2 * numStore > stimDepth)
			failRun("stim file is missing or its record counts are out of range");

		// one word per edge while the core sits in reset
		for (int i = 0; i < numProg; i++) begin
			@(posedge clk);
			progWe <= 1'b1;
			progAddr <= wordT'(i);
			progData <= stim[3 + i];
		end
		@(posedge clk);
		progWe <= 1'b0;
		if (numProg + 1 < resetCycles)
			repeat (resetCycles - numProg - 1) @(posedge clk);
		@(posedge clk);
		rstN <= 1'b1;

		// limit scales with program length
		timeoutLimit = 8 * numProg + 100;
		while ((wbSeen < numWb || storeSeen < numStore) && cycles < timeoutLimit) begin
			@(posedge clk);
			cycles++;
		end

		if (wbSeen < numWb || storeSeen < numStore) begin
			failRun($sformatf({"timeout: program did not finish in %0d cycles, ",
				"%0d of %0d register writes and %0d of %0d stores seen"},
				timeoutLimit, wbSeen, numWb, storeSeen, numStore));
		end else begin
			// late strobes from here on are caught by the monitors
			repeat (drainCycles) @(posedge clk);
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

// ==== test/clockGen.sv ====
/*
 * Free-running testbench clock.
 */
`timescale 1ns/1ps

module clockGen #(
	parameter int period = 20
) (
	output logic clk
);

	initial clk = 1'b0;

	// each level lasts half the period in ns
	always #(period / 2) clk = ~clk;

endmodule

// ==== source/mips32Top.sv ====
/*
 * Top level of the mips32 core: the four stages and the
 * ID/EX, EX/MEM and MEM/WB pipeline registers.
 */
`timescale 1ns/1ps

module mips32Top #(
	parameter int imemWords = 64,
	parameter int dmemWords = 64
) (
	input  logic clk,
	input  logic rstN,
	input  logic progWe,
	input  mips32Pkg::wordT progAddr,
	input  mips32Pkg::wordT progData,
	output logic wbValid,
	output mips32Pkg::memWbT wbRec,
	output logic storeValid,
	output mips32Pkg::storeT storeRec
);
	import mips32Pkg::*;

	wordT pc1;
	wordT instr;
	logic validId;
	logic stall;
	logic redirect;
	wordT target;
	idExT idExD;
	idExT idExQ;
	logic idValidD;
	logic idValidQ;
	exMemT exMemD;
	exMemT exMemQ;
	logic memValid;
	fwdT exDest;
	logic exIsLoad;
	fwdT memFwd;
	logic memIsLoad;
	memWbT memWbD;
	fwdT wbFwd;

	assign wbFwd = '{valid: wbValid && wbRec.regWrite, regNum: wbRec.destReg,
		value: wbRec.value};

	fetchStage #(.imemWords(imemWords)) fetch (
		.clk, .rstN, .progWe, .progAddr, .progData,
		.stall, .redirect, .target,
		.pc1, .instr, .validId
	);

	decodeStage decode (
		.clk, .rstN, .instr, .pc1, .validId,
		.exDest, .exIsLoad, .memFwd, .memIsLoad,
		.wbRec, .wbValid,
		.idEx(idExD), .idValid(idValidD),
		.stall, .redirect, .target
	);

	// a stalled instruction leaves a bubble behind it
	pipeReg #(.payloadT(idExT)) idEx (
		.clk, .rstN, .hold(1'b0), .flush(stall),
		.dIn(idExD), .validIn(idValidD), .dOut(idExQ), .validOut(idValidQ)
	);

	executeStage execute (
		.idEx(idExQ), .idValid(idValidQ), .memFwd, .wbFwd,
		.exMem(exMemD), .exDest, .exIsLoad
	);

	pipeReg #(.payloadT(exMemT)) exMem (
		.clk, .rstN, .hold(1'b0), .flush(1'b0),
		.dIn(exMemD), .validIn(idValidQ), .dOut(exMemQ), .validOut(memValid)
	);

	memoryStage #(.dmemWords(dmemWords)) memory (
		.clk, .rstN, .exMem(exMemQ), .memValid,
		.memWb(memWbD), .memFwd, .memIsLoad,
		.storeValid, .storeRec
	);

	// only real register writes reach WB as valid
	pipeReg #(.payloadT(memWbT)) memWb (
		.clk, .rstN, .hold(1'b0), .flush(1'b0),
		.dIn(memWbD), .validIn(memWbD.regWrite), .dOut(wbRec), .validOut(wbValid)
	);

endmodule

// ==== source/memoryStage.sv ====
/*
 * Memory stage: data memory, store strobe and writeback value select.
 */
`timescale 1ns/1ps

module memoryStage #(
	parameter int dmemWords = 64
) (
	input  logic clk,
	input  logic rstN,
	input  mips32Pkg::exMemT exMem,
	input  logic memValid,
	output mips32Pkg::memWbT memWb,
	output mips32Pkg::fwdT memFwd,
	output logic memIsLoad,
	output logic storeValid,
	output mips32Pkg::storeT storeRec
);
	import mips32Pkg::*;

	localparam int dmemAw = $clog2(dmemWords);

	wordT dmem [dmemWords];
	logic [dmemAw-1:0] wordIdx;
	wordT loadData;

	// word index from the bits above the byte offset
	assign wordIdx = exMem.aluResult[dmemAw+1:2];
	assign loadData = dmem[wordIdx];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < dmemWords; i++)
				dmem[i] <= '0;
		end else if (storeValid) begin
			dmem[wordIdx] <= exMem.storeData;
		end
	end

	assign storeValid = memValid && exMem.ctrl.memWrite;
	assign storeRec = '{address: exMem.aluResult, data: exMem.storeData};

	// writes to reg 0 are dropped here
	assign memWb = '{regWrite: memValid && exMem.ctrl.regWrite && (exMem.destReg != '0),
		destReg: exMem.destReg,
		value: exMem.ctrl.memToReg ? loadData : exMem.aluResult};

	assign memFwd = '{valid: memValid && exMem.ctrl.regWrite, regNum: exMem.destReg,
		value: exMem.aluResult};
	assign memIsLoad = memValid && exMem.ctrl.memRead;

endmodule

// ==== source/executeStage.sv ====
/*
 * Execute stage: forwarding unit, operand muxes, ALU and
 * destination register select.
 */
`timescale 1ns/1ps

module executeStage (
	input  mips32Pkg::idExT idEx,
	input  logic idValid,
	input  mips32Pkg::fwdT memFwd,
	input  mips32Pkg::fwdT wbFwd,
	output mips32Pkg::exMemT exMem,
	output mips32Pkg::fwdT exDest,
	output logic exIsLoad
);
	import mips32Pkg::*;

	wordT opA;
	wordT rtFwd;
	wordT opB;
	wordT aluResult;
	regAddrT destReg;

	// EX/MEM wins over MEM/WB and both win over the decode read
	always_comb begin
		if (fwdHit(memFwd, idEx.rs))
			opA = memFwd.value;
		else if (fwdHit(wbFwd, idEx.rs))
			opA = wbFwd.value;
		else
			opA = idEx.rsValue;
	end

	always_comb begin
		if (fwdHit(memFwd, idEx.rt))
			rtFwd = memFwd.value;
		else if (fwdHit(wbFwd, idEx.rt))
			rtFwd = wbFwd.value;
		else
			rtFwd = idEx.rtValue;
	end

	assign opB = idEx.ctrl.aluSrcImm ? idEx.imm : rtFwd;

	always_comb begin
		case (idEx.ctrl.aluOp)
			aluAdd: aluResult = opA + opB;
			aluSub: aluResult = opA - opB;
			aluAnd: aluResult = opA & opB;
			aluOr: aluResult = opA | opB;
			aluSlt: aluResult = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
			default: aluResult = '0;
		endcase
	end

	// rt is the target for ADDIU and LW
	assign destReg = idEx.ctrl.regDstRt ? idEx.rt : idEx.rd;

	assign exMem = '{ctrl: idEx.ctrl, aluResult: aluResult, storeData: rtFwd,
		destReg: destReg};

	// seen by decode for the branch and load-use stalls
	assign exDest = '{valid: idValid && idEx.ctrl.regWrite, regNum: destReg,
		value: aluResult};
	assign exIsLoad = idValid && idEx.ctrl.memRead;

endmodule

// ==== source/decodeStage.sv ====
/*
 * Decode stage: control decode, register file with write-through,
 * branch compare with forwarding, branch and jump targets, and
 * hazard detection.
 */
`timescale 1ns/1ps

module decodeStage (
	input  logic clk,
	input  logic rstN,
	input  mips32Pkg::wordT instr,
	input  mips32Pkg::wordT pc1,
	input  logic validId,
	input  mips32Pkg::fwdT exDest,
	input  logic exIsLoad,
	input  mips32Pkg::fwdT memFwd,
	input  logic memIsLoad,
	input  mips32Pkg::memWbT wbRec,
	input  logic wbValid,
	output mips32Pkg::idExT idEx,
	output logic idValid,
	output logic stall,
	output logic redirect,
	output mips32Pkg::wordT target
);
	import mips32Pkg::*;

	wordT regs [32];
	logic [5:0] opcode;
	logic [5:0] funct;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	wordT imm;
	wordT rsRead;
	wordT rtRead;
	wordT rsCmp;
	wordT rtCmp;
	ctrlT ctrl;
	logic regWe;
	logic isBeq;
	logic isBne;
	logic isJump;
	logic isBranch;
	logic usesRs;
	logic usesRt;
	logic hitEx;
	logic hitMem;
	logic taken;

	assign opcode = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign funct = instr[5:0];
	assign imm = {{16{instr[15]}}, instr[15:0]};

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluAdd;
		case (opcode)
			opRType: begin
				ctrl.regWrite = 1'b1;
				case (funct)
					fnAddu: ctrl.aluOp = aluAdd;
					fnSubu: ctrl.aluOp = aluSub;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOr: ctrl.aluOp = aluOr;
					fnSlt: ctrl.aluOp = aluSlt;
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			opAddiu: ctrl = '{regWrite: 1'b1, aluSrcImm: 1'b1, regDstRt: 1'b1,
				aluOp: aluAdd, default: 1'b0};
			opLw: ctrl = '{regWrite: 1'b1, memRead: 1'b1, memToReg: 1'b1,
				aluSrcImm: 1'b1, regDstRt: 1'b1, aluOp: aluAdd, default: 1'b0};
			opSw: ctrl = '{memWrite: 1'b1, aluSrcImm: 1'b1, aluOp: aluAdd, default: 1'b0};
			default: ctrl = '0;
		endcase
	end

	// register file cleared on reset and reg 0 reads as zero
	assign regWe = wbValid && wbRec.regWrite;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (regWe) begin
			regs[wbRec.destReg] <= wbRec.value;
		end
	end

	// write-through so the WB stage needs no forwarding into decode
	assign rsRead = (rs == '0) ? '0 :
		(regWe && wbRec.destReg == rs) ? wbRec.value : regs[rs];
	assign rtRead = (rt == '0) ? '0 :
		(regWe && wbRec.destReg == rt) ? wbRec.value : regs[rt];

	// branch operands may come from EX/MEM
	assign rsCmp = fwdHit(memFwd, rs) ? memFwd.value : rsRead;
	assign rtCmp = fwdHit(memFwd, rt) ? memFwd.value : rtRead;

	assign isBeq = (opcode == opBeq);
	assign isBne = (opcode == opBne);
	assign isJump = (opcode == opJ);
	assign isBranch = isBeq || isBne;
	assign usesRs = !isJump;
	assign usesRt = (opcode == opRType) || isBranch || (opcode == opSw);

	assign hitEx = (usesRs && fwdHit(exDest, rs)) || (usesRt && fwdHit(exDest, rt));
	assign hitMem = (usesRs && fwdHit(memFwd, rs)) || (usesRt && fwdHit(memFwd, rt));

	// stall on load-use, a branch on an EX result or a branch on a load in MEM
	assign stall = validId &&
		((exIsLoad && hitEx) || (isBranch && hitEx) || (isBranch && memIsLoad && hitMem));

	assign taken = (isBeq && rsCmp == rtCmp) || (isBne && rsCmp != rtCmp);
	assign redirect = validId && !stall && (taken || isJump);
	assign target = isJump ? {pc1[31:26], instr[25:0]} : pc1 + imm;

	assign idValid = validId;
	assign idEx = '{ctrl: validId ? ctrl : ctrlT'('0), rsValue: rsRead, rtValue: rtRead,
		imm: imm, rs: rs, rt: rt, rd: rd};

endmodule

// ==== source/fetchStage.sv ====
/*
 * Fetch stage: PC register, instruction memory with load port,
 * next-PC select and the IF/ID register.
 */
`timescale 1ns/1ps

module fetchStage #(
	parameter int imemWords = 64
) (
	input  logic clk,
	input  logic rstN,
	input  logic progWe,
	input  mips32Pkg::wordT progAddr,
	input  mips32Pkg::wordT progData,
	input  logic stall,
	input  logic redirect,
	input  mips32Pkg::wordT target,
	output mips32Pkg::wordT pc1,
	output mips32Pkg::wordT instr,
	output logic validId
);
	import mips32Pkg::*;

	localparam int imemAw = $clog2(imemWords);

	wordT imem [imemWords];
	wordT pc;
	wordT pcPlus1;
	wordT fetched;

	// PC counts words
	assign pcPlus1 = pc + 32'd1;
	assign fetched = imem[pc[imemAw-1:0]];

	// program load port used while the core is held in reset
	always_ff @(posedge clk) begin
		if (progWe)
			imem[progAddr[imemAw-1:0]] <= progData;
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			pc <= '0;
		else if (redirect)
			pc <= target;
		else if (!stall)
			pc <= pcPlus1;
	end

	// IF/ID holds on stall and squashes the wrong-path fetch on redirect
	always_ff @(posedge clk) begin
		if (!rstN || redirect) begin
			pc1 <= '0;
			instr <= '0;
			validId <= 1'b0;
		end else if (!stall) begin
			pc1 <= pcPlus1;
			instr <= fetched;
			validId <= 1'b1;
		end
	end

endmodule

// ==== source/pipeReg.sv ====
/*
 * Generic pipeline register with stall hold and flush to bubble.
 */
`timescale 1ns/1ps

module pipeReg #(
	parameter type payloadT = logic [31:0]
) (
	input  logic clk,
	input  logic rstN,
	input  logic hold,
	input  logic flush,
	input  payloadT dIn,
	input  logic validIn,
	output payloadT dOut,
	output logic validOut
);

	// a bubble is an all-zero payload with valid clear
	always_ff @(posedge clk) begin
		if (!rstN || flush) begin
			dOut <= '0;
			validOut <= 1'b0;
		end else if (!hold) begin
			dOut <= dIn;
			validOut <= validIn;
		end
	end

endmodule

// ==== source/mips32Pkg.sv ====
/*
 * Shared types for the mips32 core: word and register index types,
 * opcode and funct constants, ALU operation enum, pipeline-register
 * structs and the forwarding-match helper.
 */
package mips32Pkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOpT;

	// primary opcodes of the subset
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;

	// R-type funct field
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic aluSrcImm;
		logic regDstRt;
		aluOpT aluOp;
	} ctrlT;

	typedef struct packed {
		ctrlT ctrl;
		wordT rsValue;
		wordT rtValue;
		wordT imm;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
	} idExT;

	typedef struct packed {
		ctrlT ctrl;
		wordT aluResult;
		wordT storeData;
		regAddrT destReg;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		regAddrT destReg;
		wordT value;
	} memWbT;

	typedef struct packed {
		wordT address;
		wordT data;
	} storeT;

	// one forwarding source
	typedef struct packed {
		logic valid;
		regAddrT regNum;
		wordT value;
	} fwdT;

	// reg 0 never matches
	function automatic logic fwdHit(fwdT src, regAddrT r);
		return src.valid && (src.regNum == r) && (r != '0);
	endfunction

endpackage
